//--- Makefile
TOP = tb_dcache

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -f tb.f --top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	@if grep -q "Testbench failed" sim.log; then exit 1; fi
	@grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- common/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

   localparam int LINE_BYTES  = 16;
   localparam int OFFSET_BITS = 4;

   typedef logic [LINE_BYTES*8-1:0] line_t;

   // req is a single-cycle start pulse, rd and wr are levels
   typedef struct packed {
      logic        req;
      logic        wr;
      logic        rd;
      logic [31:0] addr;
      line_t       line;
   } mem_req_t;

   typedef struct packed {
      logic  avail;
      logic  done;
      line_t line;
   } mem_resp_t;

   // base address of the line holding addr
   function automatic logic [31:0] line_addr(input logic [31:0] addr);
      return {addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
   endfunction

endpackage

`default_nettype wire

//--- common/mem_op_pkg.sv
`default_nettype none

package mem_op_pkg;

   // load codes follow funct3, stores take the free codes
   typedef enum logic [2:0] {
      MEM_LB  = 3'b000,
      MEM_LH  = 3'b001,
      MEM_LW  = 3'b010,
      MEM_SB  = 3'b011,
      MEM_LBU = 3'b100,
      MEM_LHU = 3'b101,
      MEM_SH  = 3'b110,
      MEM_SW  = 3'b111
   } mem_op_t;

   // held by the core until ready and valid
   typedef struct packed {
      logic        rd;
      logic        wr;
      logic [31:0] addr;
      logic [31:0] wdata;
      mem_op_t     op;
   } core_req_t;

   typedef struct packed {
      logic        valid;
      logic        ready;
      logic [31:0] rdata;
   } core_resp_t;

endpackage

`default_nettype wire

//--- dcache/dcache_array.sv
`default_nettype none

module dcache_array
   import mem_op_pkg::*, dcache_pkg::*;
#(
   parameter int LINE_COUNT = 16
) (
   input  wire logic        clk_i,
   input  wire logic        rst_i,
   input  wire logic [31:0] addr_i,
   input  wire logic        fill_en_i,
   input  wire line_t       fill_line_i,
   input  wire logic        store_en_i,
   input  wire mem_op_t     op_i,
   input  wire logic [31:0] wdata_i,
   output logic             hit_o,
   output logic             dirty_o,
   output logic [31:0]      victim_addr_o,
   output line_t            line_o
);

   localparam int INDEX_BITS = $clog2(LINE_COUNT);
   localparam int TAG_BITS   = 32 - INDEX_BITS - OFFSET_BITS;

   logic [TAG_BITS-1:0]    tag_mem [LINE_COUNT];
   line_t                  data_mem [LINE_COUNT];
   logic [LINE_COUNT-1:0]  valid_r;
   logic [LINE_COUNT-1:0]  dirty_r;

   logic [INDEX_BITS-1:0]  index;
   logic [TAG_BITS-1:0]    tag;
   logic [OFFSET_BITS-1:0] offset;
   line_t                  base_line;
   line_t                  merged_line;

   assign offset = addr_i[OFFSET_BITS-1:0];
   assign index  = addr_i[OFFSET_BITS +: INDEX_BITS];
   assign tag    = addr_i[31 -: TAG_BITS];

   assign hit_o         = valid_r[index] && (tag_mem[index] == tag);
   assign dirty_o       = valid_r[index] && dirty_r[index];
   assign victim_addr_o = {tag_mem[index], index, {OFFSET_BITS{1'b0}}};
   assign line_o        = data_mem[index];

   // a store lands on top of fill data when both come together
   always_comb begin
      base_line   = fill_en_i ? fill_line_i : data_mem[index];
      merged_line = base_line;
      if (store_en_i) begin
         case (op_i)
            MEM_SB:  merged_line[{offset, 3'b000} +: 8]  = wdata_i[7:0];
            MEM_SH:  merged_line[{offset, 3'b000} +: 16] = wdata_i[15:0];
            MEM_SW:  merged_line[{offset, 3'b000} +: 32] = wdata_i;
            default: merged_line = base_line;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (fill_en_i || store_en_i) begin
         data_mem[index] <= merged_line;
      end
      if (fill_en_i) begin
         tag_mem[index] <= tag;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         valid_r <= '0;
         dirty_r <= '0;
      end else begin
         if (fill_en_i) begin
            valid_r[index] <= 1'b1;
         end
         // store wins over the clean fill
         if (store_en_i) begin
            dirty_r[index] <= 1'b1;
         end else if (fill_en_i) begin
            dirty_r[index] <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

//--- dcache/dcache_ctrl.sv
`default_nettype none

module dcache_ctrl
   import mem_op_pkg::*, dcache_pkg::*;
#(
   parameter int LINE_COUNT = 16
) (
   input  wire logic        clk_i,
   input  wire logic        rst_i,
   input  wire core_req_t   core_req_i,
   output core_resp_t       core_resp_o,
   output mem_req_t         mem_req_o,
   input  wire mem_resp_t   mem_resp_i,
   input  wire logic        hit_i,
   input  wire logic        dirty_i,
   input  wire logic [31:0] victim_addr_i,
   input  wire line_t       cache_line_i,
   input  wire logic [31:0] load_data_i,
   output logic             fill_en_o,
   output line_t            fill_line_o,
   output logic             store_en_o
);

   typedef enum logic [1:0] {
      LOOKUP    = 2'b00,
      WRITEBACK = 2'b01,
      FETCH     = 2'b10,
      REFILL    = 2'b11
   } state_t;

   state_t                  state_r;
   state_t                  state_ns;
   logic                    access;

   assign access       = core_req_i.rd | core_req_i.wr;

   always_comb begin
      state_ns    = state_r;
      core_resp_o = '0;
      mem_req_o   = '0;
      fill_en_o   = 1'b0;
      fill_line_o = mem_resp_i.line;
      store_en_o  = 1'b0;

      case (state_r)
         LOOKUP: begin
            if (access) begin
               if (hit_i) begin
                  // hit answers in the request cycle
                  core_resp_o.valid = 1'b1;
                  core_resp_o.ready = 1'b1;
                  core_resp_o.rdata = load_data_i;
                  store_en_o        = core_req_i.wr;
               end else if (mem_resp_i.avail) begin
                  mem_req_o.req = 1'b1;
                  if (dirty_i) begin
                     mem_req_o.wr   = 1'b1;
                     mem_req_o.addr = victim_addr_i;
                     mem_req_o.line = cache_line_i;
                     state_ns       = WRITEBACK;
                  end else begin
                     mem_req_o.rd   = 1'b1;
                     mem_req_o.addr = line_addr(core_req_i.addr);
                     state_ns       = FETCH;
                  end
               end
            end
         end

         WRITEBACK: begin
            if (mem_resp_i.done) begin
               // chain straight into the line fetch
               mem_req_o.req  = 1'b1;
               mem_req_o.rd   = 1'b1;
               mem_req_o.addr = line_addr(core_req_i.addr);
               state_ns       = FETCH;
            end else begin
               mem_req_o.wr   = 1'b1;
               mem_req_o.addr = victim_addr_i;
               mem_req_o.line = cache_line_i;
            end
         end

         FETCH: begin
            mem_req_o.rd   = 1'b1;
            mem_req_o.addr = line_addr(core_req_i.addr);
            if (mem_resp_i.done) begin
               fill_en_o = 1'b1;
               state_ns  = REFILL;
            end
         end

         REFILL: begin
            // resident line finishes like a hit
            core_resp_o.valid = 1'b1;
            core_resp_o.ready = 1'b1;
            core_resp_o.rdata = load_data_i;
            store_en_o        = core_req_i.wr;
            state_ns          = LOOKUP;
         end

         default: begin
            state_ns = LOOKUP;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         state_r <= LOOKUP;
      end else begin
         state_r <= state_ns;
      end
   end

endmodule

`default_nettype wire

//--- tb.f
common/mem_op_pkg.sv
common/dcache_pkg.sv
dcache/dcache_array.sv
dcache/dcache_ctrl.sv
verilog/load_align.sv
verilog/dcache_top.sv
testbench/tb_clock.sv
testbench/tb_main_memory.sv
testbench/tb_dcache.sv

//--- testbench/tb_clock.sv
`default_nettype none

module tb_clock #(
   parameter int PERIOD       = 100,
   parameter int RESET_CYCLES = 5
) (
   output logic clk_o,
   output logic rst_o
);

   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      clk_o = 1'b0;
      forever begin
         #(PERIOD / 2) clk_o = ~clk_o;
      end
   end

   // reset low from time zero, released on a rising edge
   initial begin
      rst_o <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      rst_o <= 1'b1;
   end

endmodule

`default_nettype wire

//--- testbench/tb_dcache.sv
`default_nettype none

module tb_dcache
   import mem_op_pkg::*, dcache_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int LINE_COUNT = 16;
   localparam int MEM_LINES  = 256;
   localparam int MAX_LAT    = 6;
   localparam int MAX_BUSY   = 16;
   // requests of all tests add up to 2 + 52 + 9 + 5 + 3 + 1
   localparam int REQ_COUNT  = 72;
   localparam int REQ_CYCLES = 2 * MAX_LAT + 10;
   localparam int RESP_LIMIT = REQ_CYCLES + MAX_BUSY;
   localparam int WATCHDOG_CYCLES = REQ_COUNT * REQ_CYCLES + MAX_BUSY + 10;

   typedef struct packed {
      logic        wr;
      logic        rd;
      logic [31:0] addr;
   } mem_event_t;

   logic        clk;
   logic        rst;
   core_req_t   core_req;
   core_resp_t  core_resp;
   mem_req_t    mem_req;
   mem_resp_t   mem_resp;
   logic        busy;
   logic [7:0]  latency;
   logic [31:0] wb_addr;
   line_t       wb_line;

   // byte-wide reference of what the core should see
   logic [7:0]  ref_mem [MEM_LINES*LINE_BYTES];
   mem_event_t  traffic [$];
   int          seed;
   int          mismatch_errors = 0;
   int          other_errors = 0;

   tb_clock #(
      .PERIOD       (100),
      .RESET_CYCLES (5)
   ) u_clock (
      .clk_o (clk),
      .rst_o (rst)
   );

   dcache_top #(
      .LINE_COUNT (LINE_COUNT)
   ) uut (
      .clk_i       (clk),
      .rst_i       (rst),
      .core_req_i  (core_req),
      .core_resp_o (core_resp),
      .mem_req_o   (mem_req),
      .mem_resp_i  (mem_resp)
   );

   tb_main_memory #(
      .LINES (MEM_LINES)
   ) u_memory (
      .clk_i      (clk),
      .rst_i      (rst),
      .mem_req_i  (mem_req),
      .mem_resp_o (mem_resp),
      .busy_i     (busy),
      .latency_i  (latency),
      .wb_addr_o  (wb_addr),
      .wb_line_o  (wb_line)
   );

   // log every request pulse
   always @(negedge clk) begin
      if (rst && mem_req.req) begin
         if (!mem_resp.avail) begin
            other_errors++;
            $display("Error at %0t ns: memory request while memory was unavailable", $time);
         end
         traffic.push_back({mem_req.wr, mem_req.rd, mem_req.addr});
      end
   end

   task automatic init_reference();
      logic [31:0] w;
      logic [11:0] a;
      seed = 32'h34d9ce4b;
      for (int l = 0; l < MEM_LINES; l++) begin
         for (int k = 0; k < 4; k++) begin
            w = $random(seed) ^ (l * LINE_BYTES + k * 4);
            a = 12'(l * LINE_BYTES + k * 4);
            for (int b = 0; b < 4; b++) begin
               ref_mem[a + 12'(b)] = w[b*8 +: 8];
            end
         end
      end
   endtask

   function automatic logic is_store(mem_op_t op);
      return (op == MEM_SB) || (op == MEM_SH) || (op == MEM_SW);
   endfunction

   function automatic logic [31:0] expected_load(mem_op_t op, logic [31:0] addr);
      logic [11:0] a;
      logic [7:0]  b0;
      logic [7:0]  b1;
      logic [7:0]  b2;
      logic [7:0]  b3;
      a  = addr[11:0];
      b0 = ref_mem[a];
      b1 = ref_mem[a + 12'd1];
      b2 = ref_mem[a + 12'd2];
      b3 = ref_mem[a + 12'd3];
      case (op)
         MEM_LB:  return {{24{b0[7]}}, b0};
         MEM_LH:  return {{16{b1[7]}}, b1, b0};
         MEM_LW:  return {b3, b2, b1, b0};
         MEM_LBU: return {24'd0, b0};
         MEM_LHU: return {16'd0, b1, b0};
         default: return 32'd0;
      endcase
   endfunction

   function automatic line_t reference_line(logic [31:0] addr);
      logic [11:0] base;
      line_t       l;
      base = {addr[11:4], 4'h0};
      for (int k = 0; k < LINE_BYTES; k++) begin
         l[k*8 +: 8] = ref_mem[base + 12'(k)];
      end
      return l;
   endfunction

   function automatic void apply_store(mem_op_t op, logic [31:0] addr, logic [31:0] data);
      logic [11:0] a;
      a = addr[11:0];
      ref_mem[a] = data[7:0];
      if (op != MEM_SB) begin
         ref_mem[a + 12'd1] = data[15:8];
      end
      if (op == MEM_SW) begin
         ref_mem[a + 12'd2] = data[23:16];
         ref_mem[a + 12'd3] = data[31:24];
      end
   endfunction

   task automatic check_word(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      if (got !== exp) begin
         mismatch_errors++;
         $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_line(input string name, input line_t got, input line_t exp);
      if (got !== exp) begin
         mismatch_errors++;
         $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_addr(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      if (got !== exp) begin
         mismatch_errors++;
         $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic expect_request(input int i, input logic wr, input logic [31:0] addr);
      if (i >= traffic.size()) begin
         other_errors++;
         $display("Error at %0t ns: memory request %0d never appeared", $time, i);
      end else begin
         check_word("memory request write flag", 32'(traffic[i].wr), 32'(wr));
         check_word("memory request read flag", 32'(traffic[i].rd), 32'(!wr));
         check_addr("memory request address", traffic[i].addr, addr);
      end
   endtask

   task automatic issue_request(input mem_op_t op, input logic [31:0] addr,
                                input logic [31:0] wdata);
      core_req_t req;
      req.wr    = is_store(op);
      req.rd    = !req.wr;
      req.addr  = addr;
      req.wdata = wdata;
      req.op    = op;
      @(posedge clk);
      core_req <= req;
   endtask

   task automatic wait_for_valid(output int cycles);
      logic seen;
      seen   = 1'b0;
      cycles = 0;
      while (!seen && cycles <= RESP_LIMIT) begin
         @(negedge clk);
         if (core_resp.valid) begin
            seen = 1'b1;
         end else begin
            cycles++;
         end
      end
      if (!seen) begin
         other_errors++;
         $display("Error at %0t ns: no response to request at %h", $time, core_req.addr);
      end else begin
         check_word("ready with valid", 32'(core_resp.ready), 32'd1);
      end
   endtask

   task automatic access_cache(input mem_op_t op, input logic [31:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output int cycles);
      issue_request(op, addr, wdata);
      wait_for_valid(cycles);
      rdata = core_resp.rdata;
      @(posedge clk);
      core_req <= '0;
   endtask

   task automatic load_and_check(input mem_op_t op, input logic [31:0] addr,
                                 output int cycles);
      logic [31:0] rdata;
      access_cache(op, addr, 32'd0, rdata, cycles);
      check_word($sformatf("%s rdata at %h", op.name(), addr), rdata,
                 expected_load(op, addr));
   endtask

   task automatic store_and_track(input mem_op_t op, input logic [31:0] addr,
                                  input logic [31:0] data);
      logic [31:0] rdata;
      int          cycles;
      access_cache(op, addr, data, rdata, cycles);
      apply_store(op, addr, data);
   endtask

   task automatic set_random_latency();
      @(posedge clk);
      latency <= 8'({$random(seed)} % (MAX_LAT + 1));
   endtask

   task automatic miss_then_hit();
      int cycles;
      traffic.delete();
      load_and_check(MEM_LW, 32'h040, cycles);
      check_word("memory request count", 32'(traffic.size()), 32'd1);
      expect_request(0, 1'b0, 32'h040);
      traffic.delete();
      load_and_check(MEM_LW, 32'h048, cycles);
      check_word("hit wait cycles", 32'(cycles), 32'd0);
      check_word("memory request count", 32'(traffic.size()), 32'd0);
   endtask

   task automatic load_extension();
      int cycles;
      set_random_latency();
      for (int off = 0; off < 16; off++) begin
         load_and_check(MEM_LB, 32'h080 + 32'(off), cycles);
         load_and_check(MEM_LBU, 32'h080 + 32'(off), cycles);
      end
      for (int off = 0; off < 16; off += 2) begin
         load_and_check(MEM_LH, 32'h080 + 32'(off), cycles);
         load_and_check(MEM_LHU, 32'h080 + 32'(off), cycles);
      end
      for (int off = 0; off < 16; off += 4) begin
         load_and_check(MEM_LW, 32'h080 + 32'(off), cycles);
      end
   endtask

   task automatic store_merge();
      int cycles;
      load_and_check(MEM_LW, 32'h0c0, cycles);
      traffic.delete();
      store_and_track(MEM_SB, 32'h0c1, $random(seed));
      store_and_track(MEM_SH, 32'h0c6, $random(seed));
      store_and_track(MEM_SW, 32'h0c8, $random(seed));
      load_and_check(MEM_LW, 32'h0c0, cycles);
      load_and_check(MEM_LW, 32'h0c4, cycles);
      load_and_check(MEM_LW, 32'h0c8, cycles);
      load_and_check(MEM_LBU, 32'h0c1, cycles);
      load_and_check(MEM_LH, 32'h0c6, cycles);
      check_word("memory request count", 32'(traffic.size()), 32'd0);
   endtask

   task automatic dirty_eviction();
      logic [31:0] victim;
      logic [31:0] other;
      int          cycles;
      victim = 32'h100;
      other  = victim + 32'(LINE_COUNT * LINE_BYTES);
      @(posedge clk);
      latency <= 8'(MAX_LAT);
      store_and_track(MEM_SW, victim, $random(seed));
      store_and_track(MEM_SB, victim + 32'd5, $random(seed));
      store_and_track(MEM_SH, victim + 32'd10, $random(seed));
      traffic.delete();
      load_and_check(MEM_LW, other + 32'd4, cycles);
      check_word("memory request count", 32'(traffic.size()), 32'd2);
      expect_request(0, 1'b1, victim);
      expect_request(1, 1'b0, other);
      check_addr("write-back address", wb_addr, victim);
      check_line("write-back line", wb_line, reference_line(victim));
      // old line returns from memory on a clean eviction
      traffic.delete();
      load_and_check(MEM_LW, victim + 32'd8, cycles);
      check_word("memory request count", 32'(traffic.size()), 32'd1);
      expect_request(0, 1'b0, victim);
   endtask

   task automatic store_miss_allocate();
      int cycles;
      set_random_latency();
      traffic.delete();
      store_and_track(MEM_SW, 32'h1d4, $random(seed));
      check_word("memory request count", 32'(traffic.size()), 32'd1);
      expect_request(0, 1'b0, 32'h1d0);
      load_and_check(MEM_LW, 32'h1d4, cycles);
      check_word("hit wait cycles", 32'(cycles), 32'd0);
      traffic.delete();
      load_and_check(MEM_LW, 32'h2d0, cycles);
      check_word("memory request count", 32'(traffic.size()), 32'd2);
      expect_request(0, 1'b1, 32'h1d0);
      expect_request(1, 1'b0, 32'h2d0);
      check_addr("write-back address", wb_addr, 32'h1d0);
      check_line("write-back line", wb_line, reference_line(32'h1d0));
   endtask

   task automatic memory_back_pressure();
      int          hold;
      int          cycles;
      logic [31:0] rdata;
      hold = 1 + int'({$random(seed)} % MAX_BUSY);
      traffic.delete();
      @(posedge clk);
      busy <= 1'b1;
      issue_request(MEM_LH, 32'h3e6, 32'd0);
      repeat (hold) begin
         @(negedge clk);
         if (mem_req.req || core_resp.ready || core_resp.valid) begin
            other_errors++;
            $display("Error at %0t ns: cache did not wait while memory was busy", $time);
         end
      end
      @(posedge clk);
      busy <= 1'b0;
      wait_for_valid(cycles);
      rdata = core_resp.rdata;
      check_word("rdata after back-pressure", rdata, expected_load(MEM_LH, 32'h3e6));
      @(posedge clk);
      core_req <= '0;
      check_word("memory request count", 32'(traffic.size()), 32'd1);
      expect_request(0, 1'b0, 32'h3e0);
   endtask

   initial begin : main
      core_req <= '0;
      busy     <= 1'b0;
      latency  <= 8'd2;
      init_reference();
      @(posedge clk);
      while (!rst) begin
         @(posedge clk);
      end
      miss_then_hit();
      load_extension();
      store_merge();
      dirty_eviction();
      store_miss_allocate();
      memory_back_pressure();
      $display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
      if (mismatch_errors + other_errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Error at %0t ns: watchdog expired before the tests finished", $time);
      $display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
      $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- testbench/tb_main_memory.sv
`default_nettype none

module tb_main_memory
   import dcache_pkg::*;
#(
   parameter int LINES = 256
) (
   input  wire logic       clk_i,
   input  wire logic       rst_i,
   input  wire mem_req_t   mem_req_i,
   output mem_resp_t       mem_resp_o,
   input  wire logic       busy_i,
   input  wire logic [7:0] latency_i,
   output logic [31:0]     wb_addr_o,
   output line_t           wb_line_o
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam int INDEX_BITS = $clog2(LINES);

   line_t                 mem [LINES];
   logic                  active;
   logic                  done_r;
   logic                  write_r;
   logic [7:0]            count_r;
   logic [INDEX_BITS-1:0] index_r;
   line_t                 line_r;
   line_t                 rdata_r;
   int                    seed;

   // each word is a random value mixed with its own byte address
   initial begin
      logic [31:0] w;
      seed = 32'h34d9ce4b;
      for (int l = 0; l < LINES; l++) begin
         for (int k = 0; k < 4; k++) begin
            w = $random(seed) ^ (l * LINE_BYTES + k * 4);
            mem[INDEX_BITS'(l)][k*32 +: 32] <= w;
         end
      end
   end

   assign mem_resp_o.avail = !busy_i && !active;
   assign mem_resp_o.done  = done_r;
   assign mem_resp_o.line  = rdata_r;

   // only the low address bits select a line
   always @(posedge clk_i) begin
      if (!rst_i) begin
         active <= 1'b0;
         done_r <= 1'b0;
      end else begin
         done_r <= 1'b0;
         if (active) begin
            if (count_r == 8'd0) begin
               active <= 1'b0;
               done_r <= 1'b1;
               if (write_r) begin
                  mem[index_r] <= line_r;
               end else begin
                  rdata_r <= mem[index_r];
               end
            end else begin
               count_r <= count_r - 8'd1;
            end
         end else if (mem_req_i.req && mem_resp_o.avail) begin
            active  <= 1'b1;
            count_r <= latency_i;
            write_r <= mem_req_i.wr;
            index_r <= mem_req_i.addr[OFFSET_BITS +: INDEX_BITS];
            line_r  <= mem_req_i.line;
            // mirror of the last write-back
            if (mem_req_i.wr) begin
               wb_addr_o <= mem_req_i.addr;
               wb_line_o <= mem_req_i.line;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/dcache_top.sv
`default_nettype none

module dcache_top
   import mem_op_pkg::*, dcache_pkg::*;
#(
   parameter int LINE_COUNT = 16
) (
   input  wire logic      clk_i,
   input  wire logic      rst_i,
   input  wire core_req_t core_req_i,
   output core_resp_t     core_resp_o,
   output mem_req_t       mem_req_o,
   input  wire mem_resp_t mem_resp_i
);

   logic        hit;
   logic        dirty;
   logic [31:0] victim_addr;
   line_t       cache_line;
   logic [31:0] load_data;
   logic        fill_en;
   line_t       fill_line;
   logic        store_en;

   dcache_ctrl #(
      .LINE_COUNT (LINE_COUNT)
   ) u_ctrl (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .core_req_i    (core_req_i),
      .core_resp_o   (core_resp_o),
      .mem_req_o     (mem_req_o),
      .mem_resp_i    (mem_resp_i),
      .hit_i         (hit),
      .dirty_i       (dirty),
      .victim_addr_i (victim_addr),
      .cache_line_i  (cache_line),
      .load_data_i   (load_data),
      .fill_en_o     (fill_en),
      .fill_line_o   (fill_line),
      .store_en_o    (store_en)
   );

   // lookup runs on the held core address
   dcache_array #(
      .LINE_COUNT (LINE_COUNT)
   ) u_array (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .addr_i        (core_req_i.addr),
      .fill_en_i     (fill_en),
      .fill_line_i   (fill_line),
      .store_en_i    (store_en),
      .op_i          (core_req_i.op),
      .wdata_i       (core_req_i.wdata),
      .hit_o         (hit),
      .dirty_o       (dirty),
      .victim_addr_o (victim_addr),
      .line_o        (cache_line)
   );

   load_align u_align (
      .line_i   (cache_line),
      .offset_i (core_req_i.addr[OFFSET_BITS-1:0]),
      .op_i     (core_req_i.op),
      .data_o   (load_data)
   );

endmodule

`default_nettype wire

//--- verilog/load_align.sv
`default_nettype none

module load_align
   import mem_op_pkg::*, dcache_pkg::*;
(
   input  wire line_t       line_i,
   input  wire logic [3:0]  offset_i,
   input  wire mem_op_t     op_i,
   output logic [31:0]      data_o
);

   line_t       shifted;
   logic [7:0]  byte_sel;
   logic [15:0] half_sel;

   // bring the addressed byte down to bit 0
   assign shifted  = line_i >> {offset_i, 3'b000};
   assign byte_sel = shifted[7:0];
   assign half_sel = shifted[15:0];

   always_comb begin
      case (op_i)
         MEM_LB:  data_o = {{24{byte_sel[7]}}, byte_sel};
         MEM_LH:  data_o = {{16{half_sel[15]}}, half_sel};
         MEM_LW:  data_o = shifted[31:0];
         MEM_LBU: data_o = {24'd0, byte_sel};
         MEM_LHU: data_o = {16'd0, half_sel};
         // stores return nothing
         default: data_o = 32'd0;
      endcase
   end

endmodule

`default_nettype wire
